/* source/soc_map_pkg.sv */
`default_nettype none

package soc_map_pkg;

    // top address bits pick the region
    localparam int selector_lsb = 27;
    localparam int selector_bits = 32 - selector_lsb;

    localparam logic [selector_bits-1:0] sel_rom = 5'd1;
    localparam logic [selector_bits-1:0] sel_ram = 5'd2;
    localparam logic [selector_bits-1:0] sel_ports = 5'd31;

    // sizes in 32-bit words
    localparam int rom_bits = 3;
    localparam int ram_bits = 6;

    // interrupt every 2**timer_bits cycles
    localparam int timer_bits = 8;

    typedef struct packed {
        logic [selector_bits-1:0] region;
        logic [selector_lsb-1:0] offset;
    } mem_addr_fields_t;

    // same word, seen whole or split into region and offset
    typedef union packed {
        logic [31:0] raw;
        mem_addr_fields_t fields;
    } mem_addr_u;

endpackage

`default_nettype wire

/* source/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

    // wstrb of zero is a read
    typedef struct packed {
        logic valid;
        soc_map_pkg::mem_addr_u addr;
        logic [31:0] wdata;
        logic [3:0] wstrb;
    } mem_req_t;

    typedef struct packed {
        logic ready;
        logic [31:0] rdata;
    } mem_rsp_t;

    // write data bits 2..0
    typedef struct packed {
        logic led;
        logic scl;
        logic sda;
    } port_out_t;

    // read data bits 6..0
    typedef struct packed {
        // con, psh, tra, trb, bak from msb down
        logic [4:0] buttons;
        logic scl_in;
        logic sda_in;
    } port_in_t;

endpackage

`default_nettype wire

/* source/bus_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_decoder (
    input wire clk,
    input wire reset,
    input wire soc_bus_pkg::mem_req_t req,
    output soc_bus_pkg::mem_rsp_t rsp,
    output logic rom_sel,
    output logic ram_sel,
    output logic port_sel,
    input wire [31:0] rom_rdata,
    input wire [31:0] ram_rdata,
    input wire [31:0] port_rdata
);

    logic busy;
    logic issue;
    logic [soc_map_pkg::selector_bits-1:0] region;
    logic [soc_map_pkg::selector_bits-1:0] region_q;

    // first cycle of a request only
    assign issue = req.valid && !busy;
    assign region = req.addr.fields.region;

    assign rom_sel = issue && (region == soc_map_pkg::sel_rom);
    assign ram_sel = issue && (region == soc_map_pkg::sel_ram);
    assign port_sel = issue && (region == soc_map_pkg::sel_ports);

    // busy doubles as the ready pulse, so a held request issues once
    always_ff @(posedge clk) begin
        if (!reset) begin
            busy <= 1'b0;
        end else begin
            busy <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            region_q <= region;
        end
    end

    always_comb begin
        rsp.ready = busy;
        case (region_q)
            soc_map_pkg::sel_rom: rsp.rdata = rom_rdata;
            soc_map_pkg::sel_ram: rsp.rdata = ram_rdata;
            soc_map_pkg::sel_ports: rsp.rdata = port_rdata;
            // unmapped reads as zero
            default: rsp.rdata = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

/* source/boot_rom.sv */
`timescale 1ns/1ns
`default_nettype none

module boot_rom (
    input wire clk,
    input wire sel,
    input wire soc_map_pkg::mem_addr_u offset,
    output logic [31:0] rdata
);

    logic [31:0] rom [0:(1 << soc_map_pkg::rom_bits)-1];
    logic [soc_map_pkg::rom_bits-1:0] word_addr;

    initial begin
        $readmemh("source/boot_rom.hex", rom);
    end

    // byte address to word index
    assign word_addr = offset.raw[soc_map_pkg::rom_bits+1:2];

    // writes never reach the array
    always_ff @(posedge clk) begin
        if (sel) begin
            rdata <= rom[word_addr];
        end
    end

endmodule

`default_nettype wire

/* source/data_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module data_ram (
    input wire clk,
    input wire sel,
    input wire soc_map_pkg::mem_addr_u offset,
    input wire [31:0] wdata,
    input wire [3:0] wstrb,
    output logic [31:0] rdata
);

    logic [soc_map_pkg::ram_bits-1:0] word_addr;

    assign word_addr = offset.raw[soc_map_pkg::ram_bits+1:2];

    // one byte array per lane
    for (genvar lane = 0; lane < 4; lane++) begin : g_lane
        logic [7:0] mem [0:(1 << soc_map_pkg::ram_bits)-1];
        logic [7:0] rd_byte;

        // old contents are read out even when the lane is written
        always_ff @(posedge clk) begin
            if (sel) begin
                if (wstrb[lane]) begin
                    mem[word_addr] <= wdata[8*lane +: 8];
                end
                rd_byte <= mem[word_addr];
            end
        end

        assign rdata[8*lane +: 8] = rd_byte;
    end

endmodule

`default_nettype wire

/* source/port_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module port_regs (
    input wire clk,
    input wire reset,
    input wire sel,
    input wire [31:0] wdata,
    input wire [3:0] wstrb,
    input wire soc_bus_pkg::port_in_t pins_in,
    output soc_bus_pkg::port_out_t pins_out,
    output logic [31:0] rdata
);

    // idle high, i2c lines released
    always_ff @(posedge clk) begin
        if (!reset) begin
            pins_out.led <= 1'b1;
            pins_out.scl <= 1'b1;
            pins_out.sda <= 1'b1;
        end else if (sel && wstrb[0]) begin
            pins_out <= soc_bus_pkg::port_out_t'(wdata[2:0]);
        end
    end

    // sampled on any select, read or write
    always_ff @(posedge clk) begin
        if (sel) begin
            rdata <= {{(32 - $bits(soc_bus_pkg::port_in_t)){1'b0}}, pins_in};
        end
    end

endmodule

`default_nettype wire

/* source/tick_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module tick_timer (
    input wire clk,
    input wire reset,
    input wire eoi,
    output logic irq
);

    logic [soc_map_pkg::timer_bits-1:0] count;

    always_ff @(posedge clk) begin
        if (!reset) begin
            count <= '0;
            irq <= 1'b0;
        end else begin
            count <= count + 1'b1;
            // wrap wins over eoi
            if (&count) begin
                irq <= 1'b1;
            end else if (eoi) begin
                irq <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* source/soc_top.sv */
`timescale 1ns/1ns
`default_nettype none

module soc_top (
    input wire clk,
    input wire reset,
    input wire soc_bus_pkg::mem_req_t req,
    output soc_bus_pkg::mem_rsp_t rsp,
    output logic mem_invalid,
    input wire eoi,
    output logic irq,
    input wire soc_bus_pkg::port_in_t pins_in,
    output soc_bus_pkg::port_out_t pins_out
);

    logic rom_sel;
    logic ram_sel;
    logic port_sel;
    logic [31:0] rom_rdata;
    logic [31:0] ram_rdata;
    logic [31:0] port_rdata;

    // request outstanding, not yet answered
    assign mem_invalid = req.valid && !rsp.ready;

    bus_decoder decoder (
        .clk(clk),
        .reset(reset),
        .req(req),
        .rsp(rsp),
        .rom_sel(rom_sel),
        .ram_sel(ram_sel),
        .port_sel(port_sel),
        .rom_rdata(rom_rdata),
        .ram_rdata(ram_rdata),
        .port_rdata(port_rdata)
    );

    boot_rom rom (
        .clk(clk),
        .sel(rom_sel),
        .offset(req.addr),
        .rdata(rom_rdata)
    );

    data_ram ram (
        .clk(clk),
        .sel(ram_sel),
        .offset(req.addr),
        .wdata(req.wdata),
        .wstrb(req.wstrb),
        .rdata(ram_rdata)
    );

    port_regs ports (
        .clk(clk),
        .reset(reset),
        .sel(port_sel),
        .wdata(req.wdata),
        .wstrb(req.wstrb),
        .pins_in(pins_in),
        .pins_out(pins_out),
        .rdata(port_rdata)
    );

    tick_timer timer (
        .clk(clk),
        .reset(reset),
        .eoi(eoi),
        .irq(irq)
    );

endmodule

`default_nettype wire

/* dv/soc_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module soc_checker (
    input wire clk,
    input wire reset,
    input wire soc_bus_pkg::mem_req_t req,
    input wire soc_bus_pkg::mem_rsp_t rsp,
    input wire mem_invalid,
    input wire irq,
    input wire soc_bus_pkg::port_out_t pins_out,
    input wire [8*24-1:0] test_name,
    input wire check_rdata,
    input wire [31:0] exp_rdata,
    input wire check_pins,
    input wire soc_bus_pkg::port_out_t exp_pins,
    input wire probe,
    input wire exp_irq,
    output int test_count,
    output int fail_count
);

    logic pending;
    logic report_due;
    logic cur_failed;
    int wait_cycles;
    logic [8*24-1:0] cur_name;
    logic cur_check_rdata;
    logic [31:0] cur_exp_rdata;
    logic cur_check_pins;
    soc_bus_pkg::port_out_t cur_exp_pins;

    // packed name to text without the leading nul bytes
    function automatic string name_text(input logic [8*24-1:0] name);
        string s;
        s = "";
        for (int i = 23; i >= 0; i--) begin
            if (name[8*i +: 8] != 8'd0) begin
                s = $sformatf("%s%c", s, name[8*i +: 8]);
            end
        end
        return s;
    endfunction

    task automatic finish_test(input logic failed, input logic [8*24-1:0] name);
        test_count++;
        if (failed) begin
            fail_count++;
        end else begin
            $display("pass  %s", name_text(name));
        end
    endtask

    // failure outside any test counts on its own
    task automatic flag_failure();
        if (pending || report_due) begin
            cur_failed = 1'b1;
        end else begin
            fail_count++;
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            pending = 1'b0;
            report_due = 1'b0;
            cur_failed = 1'b0;
            wait_cycles = 0;
            test_count = 0;
            fail_count = 0;
        end else begin
            // high only in the first cycle of a request
            if (mem_invalid !== (req.valid && !pending)) begin
                $display("MISMATCH %s: mem_invalid expected %b actual %b",
                         name_text(test_name), req.valid && !pending, mem_invalid);
                flag_failure();
            end

            // outputs settle one cycle after ready
            if (report_due) begin
                report_due = 1'b0;
                if (cur_check_pins && pins_out !== cur_exp_pins) begin
                    $display("MISMATCH %s: pins_out expected %b actual %b",
                             name_text(cur_name), cur_exp_pins, pins_out);
                    cur_failed = 1'b1;
                end
                finish_test(cur_failed, cur_name);
            end

            if (rsp.ready) begin
                if (!pending) begin
                    $display("ready was raised with no request outstanding");
                    fail_count++;
                end else begin
                    if (wait_cycles != 1) begin
                        $display("%s: ready came %0d cycles after valid instead of 1",
                                 name_text(cur_name), wait_cycles);
                        cur_failed = 1'b1;
                    end
                    if (cur_check_rdata && rsp.rdata !== cur_exp_rdata) begin
                        $display("MISMATCH %s: rdata expected %h actual %h",
                                 name_text(cur_name), cur_exp_rdata, rsp.rdata);
                        cur_failed = 1'b1;
                    end
                    pending = 1'b0;
                    report_due = 1'b1;
                end
            end else if (req.valid) begin
                // first cycle of a request
                if (!pending) begin
                    pending = 1'b1;
                    wait_cycles = 0;
                    cur_failed = 1'b0;
                    cur_name = test_name;
                    cur_check_rdata = check_rdata;
                    cur_exp_rdata = exp_rdata;
                    cur_check_pins = check_pins;
                    cur_exp_pins = exp_pins;
                end
                wait_cycles++;
            end

            if (probe) begin
                if (irq !== exp_irq) begin
                    $display("MISMATCH %s: irq expected %b actual %b",
                             name_text(test_name), exp_irq, irq);
                end
                finish_test(irq !== exp_irq, test_name);
            end
        end
    end

endmodule

`default_nettype wire

/* dv/soc_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module soc_tb;

    localparam logic [31:0] rom_base = {soc_map_pkg::sel_rom, 27'd0};
    localparam logic [31:0] ram_base = {soc_map_pkg::sel_ram, 27'd0};
    localparam logic [31:0] port_base = {soc_map_pkg::sel_ports, 27'd0};
    localparam int period = 1 << soc_map_pkg::timer_bits;
    localparam int irq_checks = 6;

    // contents of source/boot_rom.hex
    localparam logic [0:7][31:0] rom_words = {
        32'h00000013, 32'h00100093, 32'h00200113, 32'h002081b3,
        32'h00302023, 32'h00002203, 32'h0000006f, 32'hdeadbeef
    };

    typedef struct packed {
        logic [8*24-1:0] name;
        logic [31:0] addr;
        logic [3:0] wstrb;
        logic [31:0] wdata;
        soc_bus_pkg::port_in_t pins;
        logic check_rdata;
        logic [31:0] exp_rdata;
        logic check_pins;
        soc_bus_pkg::port_out_t exp_pins;
    } test_t;

    logic clk;
    logic reset;
    soc_bus_pkg::mem_req_t req;
    soc_bus_pkg::mem_rsp_t rsp;
    logic mem_invalid;
    logic eoi;
    logic irq;
    soc_bus_pkg::port_in_t pins_in;
    soc_bus_pkg::port_out_t pins_out;

    // current expectations for the checker
    logic [8*24-1:0] test_name;
    logic check_rdata;
    logic [31:0] exp_rdata;
    logic check_pins;
    soc_bus_pkg::port_out_t exp_pins;
    logic probe;
    logic exp_irq;
    int test_count;
    int fail_count;

    test_t tests[$];
    logic table_ready;
    int cycles;

    soc_top UUT (
        .clk(clk),
        .reset(reset),
        .req(req),
        .rsp(rsp),
        .mem_invalid(mem_invalid),
        .eoi(eoi),
        .irq(irq),
        .pins_in(pins_in),
        .pins_out(pins_out)
    );

    soc_checker watcher (
        .clk(clk),
        .reset(reset),
        .req(req),
        .rsp(rsp),
        .mem_invalid(mem_invalid),
        .irq(irq),
        .pins_out(pins_out),
        .test_name(test_name),
        .check_rdata(check_rdata),
        .exp_rdata(exp_rdata),
        .check_pins(check_pins),
        .exp_pins(exp_pins),
        .probe(probe),
        .exp_irq(exp_irq),
        .test_count(test_count),
        .fail_count(fail_count)
    );

    always #4 clk = ~clk;

    // edges since reset release
    always_ff @(posedge clk) begin
        if (!reset) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
        end
    end

    function automatic soc_bus_pkg::port_in_t random_pins();
        return soc_bus_pkg::port_in_t'(7'($urandom()));
    endfunction

    task automatic add_test(input logic [8*24-1:0] name, input logic [31:0] addr,
                            input logic [3:0] wstrb, input logic [31:0] wdata,
                            input soc_bus_pkg::port_in_t pins, input logic rdata_en,
                            input logic [31:0] rdata_value, input logic pins_en,
                            input logic [2:0] pins_value);
        test_t t;
        t.name = name;
        t.addr = addr;
        t.wstrb = wstrb;
        t.wdata = wdata;
        t.pins = pins;
        t.check_rdata = rdata_en;
        t.exp_rdata = rdata_value;
        t.check_pins = pins_en;
        t.exp_pins = pins_value;
        tests.push_back(t);
    endtask

    task automatic run_request(input test_t t);
        @(posedge clk);
        req.valid <= 1'b1;
        req.addr.raw <= t.addr;
        req.wdata <= t.wdata;
        req.wstrb <= t.wstrb;
        pins_in <= t.pins;
        test_name <= t.name;
        check_rdata <= t.check_rdata;
        exp_rdata <= t.exp_rdata;
        check_pins <= t.check_pins;
        exp_pins <= t.exp_pins;
        do begin
            @(posedge clk);
        end while (!rsp.ready);
        req.valid <= 1'b0;
    endtask

    // checker samples irq on the next edge
    task automatic check_irq(input logic [8*24-1:0] name, input logic value);
        test_name <= name;
        exp_irq <= value;
        probe <= 1'b1;
        @(posedge clk);
        probe <= 1'b0;
    endtask

    task automatic wait_for_cycle(input int n);
        while (cycles < n) begin
            @(posedge clk);
        end
    endtask

    initial begin
        wait (table_ready);
        repeat (tests.size() * 20 + 600) @(posedge clk);
        $display("timeout: the run did not finish in %0d cycles", tests.size() * 20 + 600);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        soc_bus_pkg::port_in_t p;
        table_ready = 1'b0;
        void'($urandom(32'h17c3daed));
        clk = 1'b0;
        reset = 1'b0;
        req = '0;
        eoi = 1'b0;
        pins_in = '0;
        test_name = '0;
        check_rdata = 1'b0;
        exp_rdata = '0;
        check_pins = 1'b0;
        exp_pins = '0;
        probe = 1'b0;
        exp_irq = 1'b0;

        for (int i = 0; i < 8; i++) begin
            add_test({"rom word ", 8'h30 + 8'(i)}, rom_base + 32'(4 * i), 4'h0, 32'h0,
                     random_pins(), 1'b1, rom_words[i], 1'b0, 3'b000);
        end
        add_test("rom write ignored", rom_base + 32'h8, 4'hf, 32'hffffffff,
                 random_pins(), 1'b0, 32'h0, 1'b0, 3'b000);
        add_test("rom word 2 after write", rom_base + 32'h8, 4'h0, 32'h0,
                 random_pins(), 1'b1, rom_words[2], 1'b0, 3'b000);
        add_test("ram full write", ram_base + 32'h14, 4'hf, 32'h11223344,
                 random_pins(), 1'b0, 32'h0, 1'b0, 3'b000);
        add_test("ram partial write", ram_base + 32'h14, 4'b0101, 32'haabbccdd,
                 random_pins(), 1'b0, 32'h0, 1'b0, 3'b000);
        add_test("ram merged readback", ram_base + 32'h14, 4'h0, 32'h0,
                 random_pins(), 1'b1, 32'h11bb33dd, 1'b0, 3'b000);
        add_test("ram top word write", ram_base + 32'hfc, 4'hf, 32'hcafef00d,
                 random_pins(), 1'b0, 32'h0, 1'b0, 3'b000);
        add_test("ram top word readback", ram_base + 32'hfc, 4'h0, 32'h0,
                 random_pins(), 1'b1, 32'hcafef00d, 1'b0, 3'b000);
        add_test("ram word 5 unchanged", ram_base + 32'h14, 4'h0, 32'h0,
                 random_pins(), 1'b1, 32'h11bb33dd, 1'b0, 3'b000);
        // outputs idle high until the first port write
        p = random_pins();
        add_test("port read after reset", port_base, 4'h0, 32'h0, p, 1'b1, {25'd0, p},
                 1'b1, 3'b111);
        add_test("port write 010", port_base, 4'b0001, 32'h2, random_pins(), 1'b0, 32'h0,
                 1'b1, 3'b010);
        p = random_pins();
        add_test("port read pins", port_base, 4'h0, 32'h0, p, 1'b1, {25'd0, p},
                 1'b1, 3'b010);
        p = random_pins();
        add_test("port read pins again", port_base, 4'h0, 32'h0, p, 1'b1, {25'd0, p},
                 1'b1, 3'b010);
        add_test("unmapped selector 5", {5'd5, 27'h40}, 4'h0, 32'h0,
                 random_pins(), 1'b1, 32'h0, 1'b0, 3'b000);
        add_test("unmapped write", 32'h10, 4'hf, 32'hffffffff,
                 random_pins(), 1'b1, 32'h0, 1'b0, 3'b000);
        table_ready = 1'b1;

        repeat (5) @(posedge clk);
        reset <= 1'b1;

        foreach (tests[i]) begin
            run_request(tests[i]);
        end

        // irq set on the wrap edge and cleared one edge after eoi
        wait_for_cycle(period - 2);
        check_irq("irq low before wrap", 1'b0);
        check_irq("irq rises at wrap", 1'b1);
        repeat (30) @(posedge clk);
        check_irq("irq held without eoi", 1'b1);
        eoi <= 1'b1;
        @(posedge clk);
        eoi <= 1'b0;
        check_irq("irq cleared by eoi", 1'b0);
        wait_for_cycle(2 * period - 2);
        check_irq("irq low before next wrap", 1'b0);
        check_irq("irq rises at next wrap", 1'b1);
        repeat (2) @(posedge clk);

        $display("tests run: %0d, failed: %0d", test_count, fail_count);
        if (fail_count == 0 && test_count == tests.size() + irq_checks) begin
            $display("All tests passed");
        end else begin
            if (test_count != tests.size() + irq_checks) begin
                $display("%0d tests finished where %0d were expected",
                         test_count, tests.size() + irq_checks);
            end
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/boot_rom.hex */
// one 32-bit word per line, word 0 first
00000013
00100093
00200113
002081b3
00302023
00002203
0000006f
deadbeef

/* build.f */
source/soc_map_pkg.sv
source/soc_bus_pkg.sv
source/bus_decoder.sv
source/boot_rom.sv
source/data_ram.sv
source/port_regs.sv
source/tick_timer.sv
source/soc_top.sv
dv/soc_checker.sv
dv/soc_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run from the project root; the ROM hex path is relative to it
cd "$(dirname "$0")" \
    && verilator --binary -Wno-fatal --top-module soc_tb -f build.f -o soc_sim \
    && ./obj_dir/soc_sim | tee /dev/stderr | grep "All tests passed" > /dev/null \
    && echo "simulation PASSED" \
    || { echo "simulation FAILED"; exit 1; }
